// File: verilog/audio_pkg.sv
package audio_pkg;

    // Width of one ADC conversion and of a filtered sample
    localparam int SAMPLE_W = 12;

    // Four conversions per averaged sample
    localparam int AVG_LOG2 = 2;

    // Accumulator must hold the sum of a whole group
    localparam int SUM_W = SAMPLE_W + AVG_LOG2;

    // Filter shift range 0 to 7
    localparam int SHIFT_W = 3;

    // Shift after reset or a center press
    localparam logic [SHIFT_W-1:0] SHIFT_DEFAULT = 3'd3;

    // One PWM period is 2**PWM_W clocks
    localparam int PWM_W = 10;

    typedef logic [SAMPLE_W-1:0] sample_t;

    typedef logic [SHIFT_W-1:0] shift_t;

    // One-cycle strobe with its sample value
    typedef struct packed {
        logic    valid;
        sample_t value;
    } audio_sample_t;

endpackage

// File: verilog/adc_sample_capture.sv
`timescale 1ns/100ps

module adc_sample_capture (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      adc_valid,
    input  audio_pkg::sample_t        adc_data,
    output audio_pkg::audio_sample_t  avg_sample
);

    // Conversions seen so far in the current group
    logic [audio_pkg::AVG_LOG2-1:0] count;
    logic [audio_pkg::SUM_W-1:0]    acc;
    logic [audio_pkg::SUM_W-1:0]    sum_next;
    logic                           avg_valid;
    audio_pkg::sample_t             avg_value;

    // Running sum including the conversion on the bus
    assign sum_next = acc + {{audio_pkg::AVG_LOG2{1'b0}}, adc_data};

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count     <= '0;
            acc       <= '0;
            avg_valid <= 1'b0;
        end else begin
            avg_valid <= 1'b0;
            if (adc_valid) begin
                // Count wraps to 0 on its own after the last one
                count <= count + 1'b1;
                if (count == '1) begin
                    acc       <= '0;
                    avg_valid <= 1'b1;
                end else begin
                    acc <= sum_next;
                end
            end
        end
    end

    // Floor of the group mean, taken as the top bits of the sum
    always_ff @(posedge clock) begin
        if (adc_valid && count == '1) begin
            avg_value <= sum_next[audio_pkg::SUM_W-1:audio_pkg::AVG_LOG2];
        end
    end

    assign avg_sample = '{valid: avg_valid, value: avg_value};

endmodule

// File: verilog/lowpass_filter.sv
`timescale 1ns/100ps

module lowpass_filter (
    input  logic                      clock,
    input  logic                      arst_n,
    input  audio_pkg::audio_sample_t  in_sample,
    input  audio_pkg::shift_t         shift,
    output audio_pkg::audio_sample_t  out_sample
);

    // Filter state, also the output value
    audio_pkg::sample_t state;
    logic               out_valid;

    // One extra bit for the sign of the difference
    logic signed [audio_pkg::SAMPLE_W:0] in_ext;
    logic signed [audio_pkg::SAMPLE_W:0] state_ext;
    logic signed [audio_pkg::SAMPLE_W:0] diff;
    logic signed [audio_pkg::SAMPLE_W:0] step;
    logic signed [audio_pkg::SAMPLE_W:0] next_ext;

    always_comb begin
        in_ext    = $signed({1'b0, in_sample.value});
        state_ext = $signed({1'b0, state});

        // Distance from the held output to the new input
        diff = in_ext - state_ext;

        // Arithmetic shift floors toward minus infinity,
        // so the step never overshoots the input
        step = diff >>> shift;

        // Shift 0 gives step equal to diff and passes the input
        next_ext = state_ext + step;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= '0;
            out_valid <= 1'b0;
        end else begin
            // Strobe follows the input strobe by one clock
            out_valid <= in_sample.valid;
            if (in_sample.valid) begin
                // Result stays between state and input, so no overflow
                state <= next_ext[audio_pkg::SAMPLE_W-1:0];
            end
        end
    end

    assign out_sample = '{valid: out_valid, value: state};

endmodule

// File: verilog/button_control.sv
`timescale 1ns/100ps

module button_control (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     btn_up,
    input  logic                     btn_down,
    input  logic                     btn_center,
    output audio_pkg::shift_t        shift
);

    // The three buttons move through the pipeline together
    typedef struct packed {
        logic up;
        logic down;
        logic center;
    } btn_t;

    btn_t btn_raw;
    btn_t sync1;
    btn_t sync2;
    btn_t prev;
    btn_t press;

    assign btn_raw = '{up: btn_up, down: btn_down, center: btn_center};

    // Two-flop synchronizer, then previous value for edge detect
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sync1 <= '0;
            sync2 <= '0;
            prev  <= '0;
        end else begin
            sync1 <= btn_raw;
            sync2 <= sync1;
            prev  <= sync2;
        end
    end

    // High for one clock on each rising edge
    assign press = sync2 & ~prev;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            shift <= audio_pkg::SHIFT_DEFAULT;
        end else if (press.center) begin
            // Center overrides up and down
            shift <= audio_pkg::SHIFT_DEFAULT;
        end else if (press.up && !press.down) begin
            if (shift != '1) shift <= shift + 1'b1;
        end else if (press.down && !press.up) begin
            if (shift != '0) shift <= shift - 1'b1;
        end
    end

endmodule

// File: verilog/pwm_serializer.sv
`timescale 1ns/100ps

module pwm_serializer (
    input  logic                clock,
    input  logic                arst_n,
    input  audio_pkg::sample_t  level,
    output logic                pwm
);

    // Free-running period counter
    logic [audio_pkg::PWM_W-1:0] count;

    // Duty held for a whole period
    logic [audio_pkg::PWM_W-1:0] duty;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            duty  <= '0;
            pwm   <= 1'b0;
        end else begin
            count <= count + 1'b1;

            // Reload only as the counter wraps to 0
            if (count == '1) begin
                duty <= level[audio_pkg::SAMPLE_W-1 -: audio_pkg::PWM_W];
            end

            // High for duty clocks per period, one clock late
            pwm <= (count < duty);
        end
    end

endmodule

// File: verilog/audio_wrapper.sv
`timescale 1ns/100ps

module audio_wrapper (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                btn_up,
    input  logic                btn_down,
    input  logic                btn_center,
    input  logic                adc_valid,
    input  audio_pkg::sample_t  adc_data,
    output logic                aud_pwm,
    output logic                aud_sd,
    output logic [15:0]         led
);

    audio_pkg::audio_sample_t avg_sample;
    audio_pkg::audio_sample_t filt_sample;
    audio_pkg::shift_t        shift;

    // Newest filtered sample and the sample-seen flag
    audio_pkg::sample_t       held_sample;
    logic                     seen;

    adc_sample_capture capture (
        .clock      (clock),
        .arst_n     (arst_n),
        .adc_valid  (adc_valid),
        .adc_data   (adc_data),
        .avg_sample (avg_sample)
    );

    lowpass_filter filter (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_sample  (avg_sample),
        .shift      (shift),
        .out_sample (filt_sample)
    );

    button_control buttons (
        .clock      (clock),
        .arst_n     (arst_n),
        .btn_up     (btn_up),
        .btn_down   (btn_down),
        .btn_center (btn_center),
        .shift      (shift)
    );

    // Sample latch, loaded by the filter strobe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            held_sample <= '0;
            seen        <= 1'b0;
        end else if (filt_sample.valid) begin
            held_sample <= filt_sample.value;
            seen        <= 1'b1;
        end
    end

    pwm_serializer serializer (
        .clock  (clock),
        .arst_n (arst_n),
        .level  (held_sample),
        .pwm    (aud_pwm)
    );

    // Seen flag, shift, then the held sample
    assign led = {seen, shift, held_sample};

    // Audio amplifier always enabled
    assign aud_sd = 1'b1;

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clock,
    output logic arst_n
);

    // 100 ns period
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Reset held for 10 clocks, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

// File: tb/audio_wrapper_assertions.sv
`timescale 1ns/100ps

module audio_wrapper_assertions #(
    parameter bit FILTER_SIDE = 1'b1
) (
    input logic               clock,
    input logic               arst_n,
    input logic               in_valid,
    input audio_pkg::sample_t in_value,
    input audio_pkg::sample_t state,
    input logic               out_valid,
    input logic               press,
    input audio_pkg::shift_t  shift
);

    // Failure total, summed by the testbench at the end
    int unsigned fail_count = 0;

    // Interval that the next filter output must land in
    audio_pkg::sample_t low_bound;
    audio_pkg::sample_t high_bound;

    assign low_bound  = (in_value < state) ? in_value : state;
    assign high_bound = (in_value < state) ? state : in_value;

    if (FILTER_SIDE) begin : g_filter
        // Output strobe exactly one clock after each input strobe
        strobe_follows: assert property (@(posedge clock) disable iff (!arst_n)
            out_valid |-> $past(in_valid))
        else begin
            $error("filter output strobe without an input strobe one clock before");
            fail_count++;
        end

        // Step never overshoots the input
        output_bounded: assert property (@(posedge clock) disable iff (!arst_n)
            in_valid |=> (state >= $past(low_bound) && state <= $past(high_bound)))
        else begin
            $error("filter output outside the old state and input");
            fail_count++;
        end
    end else begin : g_buttons
        // Shift moves only right after a press pulse
        shift_needs_press: assert property (@(posedge clock) disable iff (!arst_n)
            !$stable(shift) |-> $past(press))
        else begin
            $error("shift changed without a button press");
            fail_count++;
        end

        // Saturates at 0 and 7, never wraps around
        shift_in_range: assert property (@(posedge clock) disable iff (!arst_n)
            !$isunknown(shift)
            && !($past(shift) == 3'd7 && shift == 3'd0)
            && !($past(shift) == 3'd0 && shift == 3'd7))
        else begin
            $error("shift unknown or wrapped past its range");
            fail_count++;
        end
    end

endmodule

bind lowpass_filter audio_wrapper_assertions #(.FILTER_SIDE(1'b1)) filter_checks (
    .clock(clock), .arst_n(arst_n), .in_valid(in_sample.valid), .in_value(in_sample.value),
    .state(state), .out_valid(out_sample.valid), .press(1'b0), .shift(shift)
);

bind button_control audio_wrapper_assertions #(.FILTER_SIDE(1'b0)) button_checks (
    .clock(clock), .arst_n(arst_n), .in_valid(1'b0), .in_value('0),
    .state('0), .out_valid(1'b0), .press(|press), .shift(shift)
);

// File: tb/audio_wrapper_tb.sv
`timescale 1ns/100ps

module audio_wrapper_tb;

    logic               clock;
    logic               arst_n;
    logic               btn_up;
    logic               btn_down;
    logic               btn_center;
    logic               adc_valid;
    audio_pkg::sample_t adc_data;
    logic               aud_pwm;
    logic               aud_sd;
    logic [15:0]        led;

    // Reference model of filter state and shift
    int     model_state;
    int     model_shift;
    int     errors;
    int     tests_failed;
    int     errors_at_start;
    integer seed;

    clock_gen clocks (.clock(clock), .arst_n(arst_n));

    audio_wrapper UUT (
        .clock(clock), .arst_n(arst_n), .btn_up(btn_up), .btn_down(btn_down),
        .btn_center(btn_center), .adc_valid(adc_valid), .adc_data(adc_data),
        .aud_pwm(aud_pwm), .aud_sd(aud_sd), .led(led)
    );

    task automatic check_equal(input string what, input int got, input int expected);
        assert (got == expected) else begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED, %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    function automatic audio_pkg::sample_t random_sample();
        logic [31:0] r;
        r = $random(seed);
        return r[audio_pkg::SAMPLE_W-1:0];
    endfunction

    // Press, check the shift 3 clocks later, release
    task automatic press_buttons(input logic up, input logic down, input logic center);
        @(negedge clock);
        btn_up     = up;
        btn_down   = down;
        btn_center = center;
        if (center) model_shift = audio_pkg::SHIFT_DEFAULT;
        else if (up && !down && model_shift < 7) model_shift++;
        else if (down && !up && model_shift > 0) model_shift--;
        repeat (3) @(negedge clock);
        check_equal("shift on led", led[14:12], model_shift);
        btn_up     = 1'b0;
        btn_down   = 1'b0;
        btn_center = 1'b0;
        repeat (3) @(negedge clock);
    endtask

    // Four strobes, random gaps unless back to back
    task automatic send_group(input audio_pkg::sample_t vals [4], input bit back_to_back);
        int          sum;
        logic [31:0] r;
        sum = 0;
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            repeat (back_to_back ? 0 : int'(r[1:0])) begin
                @(negedge clock);
                adc_valid = 1'b0;
            end
            @(negedge clock);
            adc_valid = 1'b1;
            adc_data  = vals[i];
            sum += vals[i];
        end
        @(negedge clock);
        adc_valid = 1'b0;
        // Group mean, then one filter step toward it
        model_state = model_state + (((sum / 4) - model_state) >>> model_shift);
        repeat (2) @(negedge clock);
        check_equal("held sample on led", led[11:0], model_state);
        check_equal("seen flag", led[15], 1);
    endtask

    task automatic count_pwm_high(output int highs);
        highs = 0;
        repeat (1 << audio_pkg::PWM_W) begin
            @(negedge clock);
            if (aud_pwm) highs++;
        end
    endtask

    task automatic wait_for_reset(output bit released);
        int waited;
        waited = 0;
        while (arst_n !== 1'b1 && waited < 30) begin
            @(negedge clock);
            waited++;
        end
        released = (arst_n === 1'b1);
    endtask

    initial begin
        audio_pkg::sample_t vals [4];
        audio_pkg::sample_t level;
        int                 highs;
        int                 assert_fails;
        bit                 released;
        seed            = 32'h71bf;
        btn_up          = 1'b0;
        btn_down        = 1'b0;
        btn_center      = 1'b0;
        adc_valid       = 1'b0;
        adc_data        = '0;
        errors          = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        model_state     = 0;
        model_shift     = audio_pkg::SHIFT_DEFAULT;
        wait_for_reset(released);
        if (!released) begin
            $display("Timeout: reset was never released");
            $display("sim failed");
        end else begin
            // Reset state, PWM silent for a whole period
            check_equal("led after reset", led, 16'h3000);
            check_equal("aud_sd", aud_sd, 1);
            count_pwm_high(highs);
            check_equal("PWM high cycles after reset", highs, 0);
            end_test("reset_state");

            repeat (6) press_buttons(1'b1, 1'b0, 1'b0);
            repeat (8) press_buttons(1'b0, 1'b1, 1'b0);
            press_buttons(1'b0, 1'b0, 1'b1);
            repeat (2) press_buttons(1'b0, 1'b1, 1'b0);
            // Center beats up, which alone would give 2
            press_buttons(1'b1, 1'b0, 1'b1);
            end_test("shift_control");

            // Shift 0 so the held sample is the plain mean
            repeat (3) press_buttons(1'b0, 1'b1, 1'b0);
            for (int g = 0; g < 6; g++) begin
                foreach (vals[i]) vals[i] = random_sample();
                send_group(vals, g % 2 == 0);
            end
            end_test("averaging");

            repeat (2) press_buttons(1'b1, 1'b0, 1'b0);
            level = random_sample();
            vals  = '{level, level, level, level};
            repeat (4) send_group(vals, 1'b0);
            repeat (3) press_buttons(1'b1, 1'b0, 1'b0);
            level = random_sample();
            vals  = '{level, level, level, level};
            repeat (4) send_group(vals, 1'b1);
            end_test("filter_response");

            repeat (5) press_buttons(1'b0, 1'b1, 1'b0);
            for (int k = 0; k < 3; k++) begin
                // Last level has zero duty
                level = (k == 2) ? (random_sample() & 12'h003) : random_sample();
                vals  = '{level, level, level, level};
                send_group(vals, 1'b1);
                // One full period so the duty reloads
                repeat (1 << audio_pkg::PWM_W) @(negedge clock);
                count_pwm_high(highs);
                check_equal("PWM high cycles", highs, level >> 2);
            end
            end_test("pwm_duty");

            assert_fails = UUT.filter.filter_checks.fail_count
                         + UUT.buttons.button_checks.fail_count;
            $display("tests 5, failed %0d, errors %0d, assertion failures %0d",
                     tests_failed, errors, assert_fails);
            if (errors == 0 && tests_failed == 0 && assert_fails == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
        end
        $finish;
    end

endmodule

// File: project.f
verilog/audio_pkg.sv
verilog/adc_sample_capture.sv
verilog/lowpass_filter.sv
verilog/button_control.sv
verilog/pwm_serializer.sv
verilog/audio_wrapper.sv
tb/clock_gen.sv
tb/audio_wrapper_assertions.sv
tb/audio_wrapper_tb.sv

// File: Bender.yml
package:
  name: audio_wrapper

sources:
  - files:
      - verilog/audio_pkg.sv
      - verilog/adc_sample_capture.sv
      - verilog/lowpass_filter.sv
      - verilog/button_control.sv
      - verilog/pwm_serializer.sv
      - verilog/audio_wrapper.sv
  - target: test
    files:
      - tb/clock_gen.sv
      - tb/audio_wrapper_assertions.sv
      - tb/audio_wrapper_tb.sv
